// File: logic/busMap_defs.svh
// Bus widths and Zorro 2 region address bits
// Autoconfig register offset and board identity bytes
`ifndef BUS_MAP_DEFS_SVH
`define BUS_MAP_DEFS_SVH

// CPU address and APB byte lane
`define BUS_ADDR_W 32
`define BUS_DATA_W 8

// Address bits 31..24 of Zorro 2 space
`define Z2_HIGH_BYTE 8'h00

// Region selects on address bits 23..16
`define REGION_CIA 8'hBF
`define REGION_CUSTOM 8'hDF
`define REGION_AUTOCONFIG 8'hE8
// RTC spans $DC and $DD so only bits 23..17 count
`define REGION_RTC 7'h6E

// ROM on bits 23..19 and chip RAM on bits 23..21
`define ROM_LOW_BITS 5'h00
`define ROM_HIGH_BITS 5'h1F
`define CHIP_RAM_BITS 3'h0

// Interrupt acknowledge space on bits 31..16
`define AUTOVECTOR_HIGH 16'hFFFF

// Base address register in the autoconfig window
`define AC_BASE_REG 8'h48

// Zorro 2 card with boot ROM vector, 128 KB
`define AC_ID_TYPE 8'hD2
`define AC_ID_PRODUCT 8'h0C
`define AC_ID_MFG_HI 8'h13
`define AC_ID_MFG_LO 8'h6D

`endif

// File: logic/cpuBusPkg.sv
// CPU bus side types
// 68040 transfer type encoding
package cpuBusPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer type
  ////////////////////////////////////////////////////////////////////////////

  // TT1..TT0 as the 68040 drives them with each bus cycle
  // Normal covers user and supervisor, code and data
  // MOVE16 line transfers
  // Alternate access into function code space
  // Interrupt acknowledge puts the level on A3..A1
  typedef enum logic [1:0] {
    normal    = 2'b00,
    moveBlock = 2'b01,
    altAccess = 2'b10,
    intAck    = 2'b11
  } transferType;

  // Only intAck matters to the glue
  // The other codes decode as plain memory cycles

endpackage

// File: logic/memMapPkg.sv
// Memory map types
// Decoded region and ATA register select
package memMapPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Decoded region
  ////////////////////////////////////////////////////////////////////////////

  // At most one region per CPU access
  // Autovector is the only region outside Zorro 2 space
  typedef enum logic [3:0] {
    regNone       = 4'd0,
    regRom        = 4'd1,
    regChipRam    = 4'd2,
    regCustom     = 4'd3,
    regCia        = 4'd4,
    regRtc        = 4'd5,
    regAutoconfig = 4'd6,
    regAta        = 4'd7,
    regAutovector = 4'd8
  } mapRegion;

  ////////////////////////////////////////////////////////////////////////////
  // ATA register select
  ////////////////////////////////////////////////////////////////////////////

  // Primary and secondary channel, CS0 and CS1 banks
  typedef enum logic [2:0] {
    ataNone = 3'd0,
    priCs0  = 3'd1,
    priCs1  = 3'd2,
    secCs0  = 3'd3,
    secCs1  = 3'd4
  } ataSelect;

endpackage

// File: logic/addressDecode.sv
// Zorro 2 address decode for the 68040 local bus
// Region selects, CIA and ATA chip selects, ATA enable latch
`timescale 1ns/1ns
`include "busMap_defs.svh"

module addressDecode (
  input  logic                   CLK40,
  input  logic                   RESETn,
  input  logic [`BUS_ADDR_W-1:0] PADDR,
  input  logic                   PWRITE,
  input  logic                   access,
  input  cpuBusPkg::transferType tt,
  input  logic                   ovl,
  input  logic                   ciaEnable,
  input  logic                   configured,
  input  logic [7:1]             ataBase,
  output logic                   romEn,
  output logic                   ciaSpace,
  output logic                   ciaCs0N,
  output logic                   ciaCs1N,
  output logic                   ramSpaceN,
  output logic                   regSpaceN,
  output logic                   autovector,
  output logic                   rtcEnN,
  output logic                   autoconfigSpace,
  output logic                   ataSpace,
  output logic                   ataEnN,
  output logic                   pcs0,
  output logic                   pcs1,
  output logic                   scs0,
  output logic                   scs1
);
  import cpuBusPkg::*;
  import memMapPkg::*;

  mapRegion region;
  ataSelect ataSel;
  logic     z2Space;
  logic     lowRom;
  logic     hiRom;
  logic     ataEnable;

  ////////////////////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////////////////////

  // Low 16 MB only, nothing decodes in reset
  assign z2Space = RESETn && (PADDR[31:24] == `Z2_HIGH_BYTE);

  // Reset vector maps to ROM while overlay is set
  assign lowRom = (PADDR[23:19] == `ROM_LOW_BITS) && ovl;
  // Kickstart runs from high ROM before it drops overlay
  assign hiRom = PADDR[23:19] == `ROM_HIGH_BITS;

  always_comb begin
    region = regNone;
    // Interrupt acknowledge cycles are all autovectored
    if (RESETn && tt == intAck && PADDR[31:16] == `AUTOVECTOR_HIGH) begin
      region = regAutovector;
    end else if (z2Space) begin
      if (lowRom || hiRom) begin
        region = regRom;
      end else if (!ovl && PADDR[23:21] == `CHIP_RAM_BITS) begin
        region = regChipRam;
      end else if (PADDR[23:16] == `REGION_CUSTOM) begin
        region = regCustom;
      end else if (PADDR[23:16] == `REGION_CIA) begin
        region = regCia;
      end else if (PADDR[23:17] == `REGION_RTC) begin
        region = regRtc;
      end else if (PADDR[23:16] == `REGION_AUTOCONFIG) begin
        region = regAutoconfig;
      end else if (configured && PADDR[23:17] == ataBase) begin
        // 128 KB block placed by the host
        region = regAta;
      end
    end
  end

  assign romEn           = region == regRom;
  assign ramSpaceN       = region != regChipRam;
  assign regSpaceN       = region != regCustom;
  assign ciaSpace        = region == regCia;
  assign rtcEnN          = region != regRtc;
  assign autoconfigSpace = region == regAutoconfig;
  assign ataSpace        = region == regAta;
  assign autovector      = region == regAutovector;

  // CIA A on A12 low and CIA B on A13 low
  assign ciaCs0N = !(RESETn && ciaEnable && !PADDR[12]);
  assign ciaCs1N = !(RESETn && ciaEnable && !PADDR[13]);

  ////////////////////////////////////////////////////////////////////////////
  // ATA
  ////////////////////////////////////////////////////////////////////////////

  // Bits 16..12 pick the channel and bank
  always_comb begin
    case (PADDR[16:12])
      5'b00001: ataSel = priCs0;
      5'b00101: ataSel = priCs1;
      5'b00010: ataSel = secCs0;
      5'b00110: ataSel = secCs1;
      default:  ataSel = ataNone;
    endcase
  end

  // Boot ROM answers until the first write into the space
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEnable <= 1'b0;
    end else if (access && PWRITE && ataSpace) begin
      ataEnable <= 1'b1;
    end
  end

  assign ataEnN = !(ataSpace && ataEnable);

  // Drive selects only in register mode
  assign pcs0 = !ataEnN && ataSel == priCs0;
  assign pcs1 = !ataEnN && ataSel == priCs1;
  assign scs0 = !ataEnN && ataSel == secCs0;
  assign scs1 = !ataEnN && ataSel == secCs1;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  ataSelOneHot: assert property (@(posedge CLK40) $onehot0({pcs0, pcs1, scs0, scs1}))
    else $error("More than one ATA chip select active");

  // Register mode needs a configured board and a hit on its base
  ataEnInSpace: assert property (@(posedge CLK40)
    !ataEnN |-> (region == regAta) && configured)
    else $error("ATA enabled outside configured ATA space");

  // Latch only clears through reset
  ataEnSticky: assert property (@(posedge CLK40) $fell(ataEnable) |-> !$past(RESETn))
    else $error("ATA enable dropped without reset");

endmodule

// File: logic/autoconfigRegs.sv
// Zorro 2 autoconfig register block as an APB slave
// Identity nibble reads, base address latch, ready generation
`timescale 1ns/1ns
`include "busMap_defs.svh"

module autoconfigRegs (
  input  logic                   CLK40,
  input  logic                   RESETn,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  logic                   PWRITE,
  input  logic [7:0]             PADDR,
  input  logic [`BUS_DATA_W-1:0] PWDATA,
  input  logic                   autoconfigSpace,
  output logic [`BUS_DATA_W-1:0] PRDATA,
  output logic                   PREADY,
  output logic                   configured,
  output logic [7:1]             ataBase
);
  localparam logic [7:0] idType    = `AC_ID_TYPE;
  localparam logic [7:0] idProduct = `AC_ID_PRODUCT;
  localparam logic [7:0] idMfgHi   = `AC_ID_MFG_HI;
  localparam logic [7:0] idMfgLo   = `AC_ID_MFG_LO;

  logic                   setupPhase;
  logic                   baseWrite;
  logic [3:0]             idNibble;
  logic [`BUS_DATA_W-1:0] readValue;

  assign setupPhase = PSEL && !PENABLE;

  // Host writes the base byte and the board leaves the chain
  assign baseWrite = PSEL && PENABLE && PREADY && PWRITE && autoconfigSpace &&
                     !configured && (PADDR == `AC_BASE_REG);

  // Nibbles sit on the upper half of the byte lane
  // Type reads true
  // Everything after it reads inverted
  always_comb begin
    case (PADDR)
      8'h00:   idNibble = idType[7:4];
      8'h02:   idNibble = idType[3:0];
      8'h04:   idNibble = ~idProduct[7:4];
      8'h06:   idNibble = ~idProduct[3:0];
      8'h10:   idNibble = ~idMfgHi[7:4];
      8'h12:   idNibble = ~idMfgHi[3:0];
      8'h14:   idNibble = ~idMfgLo[7:4];
      8'h16:   idNibble = ~idMfgLo[3:0];
      // Unused registers read as inverted zero
      default: idNibble = 4'hF;
    endcase
  end

  assign readValue = (!PWRITE && autoconfigSpace && !configured) ?
                     {idNibble, 4'hF} : 8'hFF;

  // No wait states, ready follows every setup phase
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      PREADY <= 1'b0;
    end else begin
      PREADY <= setupPhase;
    end
  end

  // Read data loads for the access phase and idles at $FF
  always_ff @(posedge CLK40) begin
    if (setupPhase) begin
      PRDATA <= readValue;
    end else begin
      PRDATA <= 8'hFF;
    end
  end

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      configured <= 1'b0;
    end else if (baseWrite) begin
      configured <= 1'b1;
    end
  end

  // A23..A17 of the ATA block
  always_ff @(posedge CLK40) begin
    if (baseWrite) begin
      ataBase <= PWDATA[7:1];
    end
  end

  readyInAccess: assert property (@(posedge CLK40) disable iff (!RESETn)
    PSEL && PENABLE |-> PREADY)
    else $error("PREADY low in APB access phase");

endmodule

// File: logic/busGlue.sv
// Top level of the bus glue
// APB port, address decoder and autoconfig block
`timescale 1ns/1ns
`include "busMap_defs.svh"

module busGlue (
  input  logic                   CLK40,
  input  logic                   RESETn,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  logic                   PWRITE,
  input  logic [`BUS_ADDR_W-1:0] PADDR,
  input  logic [`BUS_DATA_W-1:0] PWDATA,
  input  cpuBusPkg::transferType tt,
  input  logic                   ovl,
  input  logic                   ciaEnable,
  output logic [`BUS_DATA_W-1:0] PRDATA,
  output logic                   PREADY,
  output logic                   romEn,
  output logic                   ciaSpace,
  output logic                   ciaCs0N,
  output logic                   ciaCs1N,
  output logic                   ramSpaceN,
  output logic                   regSpaceN,
  output logic                   autovector,
  output logic                   rtcEnN,
  output logic                   autoconfigSpace,
  output logic                   ataSpace,
  output logic                   ataEnN,
  output logic                   pcs0,
  output logic                   pcs1,
  output logic                   scs0,
  output logic                   scs1
);
  logic       configured;
  logic [7:1] ataBase;

  // APB access phase
  wire access = PSEL && PENABLE;

  addressDecode decode (
    .CLK40, .RESETn, .PADDR, .PWRITE, .access, .tt, .ovl, .ciaEnable,
    .configured, .ataBase,
    .romEn, .ciaSpace, .ciaCs0N, .ciaCs1N, .ramSpaceN, .regSpaceN,
    .autovector, .rtcEnN, .autoconfigSpace, .ataSpace, .ataEnN,
    .pcs0, .pcs1, .scs0, .scs1
  );

  // Only the low address byte reaches the register block
  autoconfigRegs acRegs (
    .CLK40, .RESETn, .PSEL, .PENABLE, .PWRITE,
    .PADDR(PADDR[7:0]),
    .PWDATA, .autoconfigSpace,
    .PRDATA, .PREADY, .configured, .ataBase
  );

endmodule

// File: verif/busGlueTb.sv
// Testbench for the bus glue top level
// Pattern file reader, APB driver, output checks and run verdict
`timescale 1ns/1ns
`include "busMap_defs.svh"

module busGlueTb;
  import cpuBusPkg::*;
  import memMapPkg::*;

  // Clock cycles allowed for PREADY in one access phase
  localparam int readyTimeout = 16;

  logic                   CLK40;
  logic                   RESETn;
  logic                   PSEL;
  logic                   PENABLE;
  logic                   PWRITE;
  logic [`BUS_ADDR_W-1:0] PADDR;
  logic [`BUS_DATA_W-1:0] PWDATA;
  transferType            tt;
  logic                   ovl;
  logic                   ciaEnable;
  logic [`BUS_DATA_W-1:0] PRDATA;
  logic                   PREADY;
  logic                   romEn;
  logic                   ciaSpace;
  logic                   ciaCs0N;
  logic                   ciaCs1N;
  logic                   ramSpaceN;
  logic                   regSpaceN;
  logic                   autovector;
  logic                   rtcEnN;
  logic                   autoconfigSpace;
  logic                   ataSpace;
  logic                   ataEnN;
  logic                   pcs0;
  logic                   pcs1;
  logic                   scs0;
  logic                   scs1;

  // Pattern file fields
  int         fd;
  int         fields;
  int         patternCount;
  string      line;
  byte        opChar;
  logic [31:0] addr;
  logic [7:0]  wdata;
  int         ttNum;
  int         ovlNum;
  int         ciaNum;
  logic [10:0] expFlags;
  int         selNum;
  logic [7:0]  expData;

  // Decoder outputs from the MSB of the expectation word down
  string outNames [15] = '{
    "romEn", "ciaSpace", "ciaCs0N", "ciaCs1N", "ramSpaceN", "regSpaceN", "autovector",
    "rtcEnN", "autoconfigSpace", "ataSpace", "ataEnN", "pcs0", "pcs1", "scs0", "scs1"
  };

  // 4 ns period
  always #2 CLK40 = ~CLK40;

  busGlue uut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("Fail at %0t ns: %s expected %h, got %h",
                        $time, name, expected, actual));
    end
  endtask

  // Select bits expand from the expected ATA select code
  task automatic checkOutputs(input logic [10:0] flags, input ataSelect sel,
                              input logic [7:0] data);
    logic [14:0] expWord;
    logic [14:0] actWord;
    expWord = {flags, sel == priCs0, sel == priCs1, sel == secCs0, sel == secCs1};
    actWord = {romEn, ciaSpace, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, autovector,
               rtcEnN, autoconfigSpace, ataSpace, ataEnN, pcs0, pcs1, scs0, scs1};
    for (int i = 0; i < 15; i++) begin
      checkValue(outNames[i], 8'(expWord[14-i]), 8'(actWord[14-i]));
    end
    checkValue("PRDATA", data, PRDATA);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  // PREADY sampled on falling edges of the access phase
  task automatic waitReady(output int waits);
    int cycles;
    cycles = 0;
    @(negedge CLK40);
    while (!PREADY) begin
      if (cycles >= readyTimeout) begin
        failRun("APB bus hung: PREADY stayed low in the access phase");
      end else begin
        cycles++;
        @(negedge CLK40);
      end
    end
    waits = cycles;
  endtask

  task automatic runAccess(input logic write, input logic [31:0] a, input logic [7:0] d,
                           input transferType ttVal, input logic ovlVal,
                           input logic ciaVal, input logic [10:0] flags,
                           input ataSelect sel, input logic [7:0] data);
    int waits;
    // Setup phase
    @(posedge CLK40);
    PSEL      <= 1'b1;
    PENABLE   <= 1'b0;
    PWRITE    <= write;
    PADDR     <= a;
    PWDATA    <= d;
    tt        <= ttVal;
    ovl       <= ovlVal;
    ciaEnable <= ciaVal;
    // Access phase
    @(posedge CLK40);
    PENABLE <= 1'b1;
    waitReady(waits);
    // Zero wait states on this bus
    checkValue("PREADY wait cycles", 8'd0, 8'(waits));
    checkOutputs(flags, sel, data);
    // Completing edge then idle bus
    @(posedge CLK40);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  // Two cycles of reset with the decoder inputs held
  task automatic runReset(input logic [31:0] a, input transferType ttVal,
                          input logic ovlVal, input logic ciaVal,
                          input logic [10:0] flags, input ataSelect sel,
                          input logic [7:0] data);
    @(posedge CLK40);
    RESETn    <= 1'b0;
    PADDR     <= a;
    tt        <= ttVal;
    ovl       <= ovlVal;
    ciaEnable <= ciaVal;
    @(posedge CLK40);
    @(negedge CLK40);
    checkOutputs(flags, sel, data);
    @(posedge CLK40);
    RESETn <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    CLK40        = 1'b0;
    RESETn       = 1'b0;
    PSEL         = 1'b0;
    PENABLE      = 1'b0;
    PWRITE       = 1'b0;
    PADDR        = '0;
    PWDATA       = '0;
    tt           = normal;
    ovl          = 1'b1;
    ciaEnable    = 1'b0;
    patternCount = 0;
    repeat (2) @(posedge CLK40);
    RESETn <= 1'b1;

    fd = $fopen("verif/decodePatterns.txt", "r");
    if (fd == 0) begin
      failRun("Cannot open the pattern file verif/decodePatterns.txt");
    end else begin
      while (!$feof(fd)) begin
        // Skip blank lines and column notes
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%c %h %h %d %d %d %b %d %h", opChar, addr, wdata,
                           ttNum, ovlNum, ciaNum, expFlags, selNum, expData);
          patternCount++;
          if (fields != 9) begin
            failRun($sformatf("Malformed pattern line: %s", line));
          end else if (opChar == "x") begin
            runReset(addr, transferType'(ttNum[1:0]), ovlNum[0], ciaNum[0], expFlags,
                     ataSelect'(selNum[2:0]), expData);
          end else if (opChar == "r" || opChar == "w") begin
            runAccess(opChar == "w", addr, wdata, transferType'(ttNum[1:0]), ovlNum[0],
                      ciaNum[0], expFlags, ataSelect'(selNum[2:0]), expData);
          end else begin
            failRun($sformatf("Unknown operation in pattern line: %s", line));
          end
        end
      end
      $fclose(fd);
      if (patternCount == 0) begin
        failRun("The pattern file holds no access lines");
      end else begin
        $display("Simulation finished: PASS");
        $finish;
      end
    end
  end

endmodule

// File: verif/decodePatterns.txt
# op addr wdata tt ovl cia flags sel prdata; op r read, w write, x reset with PSEL low
# flags romEn ciaSpace ciaCs0N ciaCs1N ramSpaceN regSpaceN autovector rtcEnN autoconfigSpace ataSpace ataEnN
# tt 0 normal 3 intAck; sel 0 none 1 priCs0 2 priCs1 3 secCs0 4 secCs1
r 00000000 00 0 1 0 10111101001 0 FF
r 00000000 00 0 0 0 00110101001 0 FF
r 00F80000 00 0 1 0 10111101001 0 FF
r 00F80000 00 0 0 0 10111101001 0 FF
r 00BFE001 00 0 0 0 01111101001 0 FF
r 00BFE001 00 0 0 1 01011101001 0 FF
r 00BFD000 00 0 0 1 01101101001 0 FF
r 00DFF000 00 0 0 0 00111001001 0 FF
r 00DC0000 00 0 0 0 00111100001 0 FF
r 00DD0000 00 0 0 0 00111100001 0 FF
r 01BFE001 00 0 0 0 00111101001 0 FF
r 01DFF000 00 0 0 0 00111101001 0 FF
r FFFFFFF4 00 3 0 0 00111111001 0 FF
r FFFFFFF4 00 0 0 0 00111101001 0 FF
r 00E80000 00 0 0 0 00111101101 0 DF
r 00E80002 00 0 0 0 00111101101 0 2F
r 00E80004 00 0 0 0 00111101101 0 FF
r 00E80006 00 0 0 0 00111101101 0 3F
r 00E80010 00 0 0 0 00111101101 0 EF
r 00E80012 00 0 0 0 00111101101 0 CF
r 00E80014 00 0 0 0 00111101101 0 9F
r 00E80016 00 0 0 0 00111101101 0 2F
r 00EA0000 00 0 0 0 00111101001 0 FF
w 00E80048 EA 0 0 0 00111101101 0 FF
r 00E80000 00 0 0 0 00111101101 0 FF
r 00EA0000 00 0 0 0 00111101011 0 FF
r 00EA1000 00 0 0 0 00111101011 0 FF
w 00EA1000 00 0 0 0 00111101011 0 FF
r 00EA1000 00 0 0 0 00111101010 1 FF
r 00EA5000 00 0 0 0 00111101010 2 FF
r 00EA2000 00 0 0 0 00111101010 3 FF
r 00EA6000 00 0 0 0 00111101010 4 FF
r 00EB1000 00 0 0 0 00111101010 0 FF
x 00EA1000 00 0 0 1 00111101001 0 FF
r 00EA1000 00 0 0 0 00111101001 0 FF
r 00E80000 00 0 0 0 00111101101 0 DF
r 00000000 00 0 1 0 10111101001 0 FF

// File: all.f
+incdir+logic
logic/cpuBusPkg.sv
logic/memMapPkg.sv
logic/addressDecode.sv
logic/autoconfigRegs.sv
logic/busGlue.sv
verif/busGlueTb.sv

// File: Makefile
# Verilator flow for the bus glue testbench

VERILATOR := verilator
TOP       := busGlueTb
FILELIST  := all.f
OBJDIR    := obj_dir
SIMFLAGS  := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
PASS_MSG  := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
